//--- logic/qerv_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_alu (
   input  logic              clk,
   input  logic              i_arst_n,
   input  qerv_pkg::nibble_t i_rs1,
   input  qerv_pkg::nibble_t i_rs2,
   qerv_step_if.user         step,
   qerv_dec_if.alu           dec,
   output qerv_pkg::nibble_t o_rd
);

   qerv_pkg::nibble_t op_b;
   qerv_pkg::nibble_t op_b_inv;
   logic              sub;
   logic              carry;
   logic              c_in;
   logic [`QERV_W:0]  add_r;

   assign sub  = (dec.alu_op == qerv_pkg::ALU_SUB);
   assign op_b = dec.op_b_imm ? dec.imm_nib : i_rs2;

   // Two's complement subtract, invert B and seed carry with 1
   assign op_b_inv = sub ? ~op_b : op_b;
   assign c_in     = step.cnt0 ? sub : carry;
   assign add_r    = {1'b0, i_rs1} + {1'b0, op_b_inv} + {{`QERV_W{1'b0}}, c_in};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         carry <= 1'b0;
      else if (step.cnt_en)
         carry <= add_r[`QERV_W];
   end

   always_comb begin
      case (dec.alu_op)
         qerv_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         qerv_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         qerv_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         default:           o_rd = add_r[`QERV_W-1:0];
      endcase
   end

endmodule
`default_nettype wire

//--- logic/qerv_config.svh
`ifndef QERV_CONFIG_SVH
`define QERV_CONFIG_SVH

// Bits handled per clock
`define QERV_W 4

// Nibble steps per instruction
`define QERV_STEPS 8

// Data and address word width
`define QERV_XLEN 32

// Register index width
`define QERV_RAW 5

// First fetch address after reset
`define QERV_RESET_PC 32'h0000_0000

`endif

//--- logic/qerv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_ctrl (
   input  logic              clk,
   input  logic              i_arst_n,
   qerv_step_if.user         step,
   qerv_dec_if.ctrl          dec,
   output qerv_pkg::word_t   o_ibus_adr,
   output qerv_pkg::nibble_t o_link
);

   qerv_pkg::word_t   pc;
   qerv_pkg::nibble_t pc_nib;
   qerv_pkg::nibble_t inc_nib;
   qerv_pkg::nibble_t new_nib;
   logic              c_inc;
   logic              c_jmp;
   logic              c_inc_in;
   logic              c_jmp_in;
   logic [`QERV_W:0]  sum_inc;
   logic [`QERV_W:0]  sum_jmp;

   // Current PC nibble, least significant first
   assign pc_nib = pc[`QERV_W-1:0];

   // The constant 4 only lives in nibble 0
   assign inc_nib  = step.cnt0 ? qerv_pkg::nibble_t'(4) : '0;
   assign c_inc_in = step.cnt0 ? 1'b0 : c_inc;
   assign c_jmp_in = step.cnt0 ? 1'b0 : c_jmp;

   assign sum_inc = {1'b0, pc_nib} + {1'b0, inc_nib} + {{`QERV_W{1'b0}}, c_inc_in};
   assign sum_jmp = {1'b0, pc_nib} + {1'b0, dec.imm_nib} + {{`QERV_W{1'b0}}, c_jmp_in};

   // Jump target for JAL, otherwise the next word
   assign new_nib = dec.jal ? sum_jmp[`QERV_W-1:0] : sum_inc[`QERV_W-1:0];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc    <= `QERV_RESET_PC;
         c_inc <= 1'b0;
         c_jmp <= 1'b0;
      end else if (step.cnt_en) begin
         // New PC rotates in from the top, full after the last step
         pc    <= {new_nib, pc[`QERV_XLEN-1:`QERV_W]};
         c_inc <= sum_inc[`QERV_W];
         c_jmp <= sum_jmp[`QERV_W];
      end
   end

   assign o_ibus_adr = pc;
   assign o_link     = sum_inc[`QERV_W-1:0];

endmodule
`default_nettype wire

//--- logic/qerv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_decode (
   input  logic            clk,
   input  logic            i_arst_n,
   input  qerv_pkg::word_t i_ibus_rdt,
   input  logic            i_ibus_ack,
   qerv_step_if.user       step,
   qerv_dec_if.dec         dec
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   logic [6:0]        opcode;
   logic [2:0]        funct3;
   logic              f3_ok;
   qerv_pkg::alu_op_e d_alu_op;
   qerv_pkg::rd_src_e d_src;
   logic              d_wen;
   logic              d_op_b_imm;
   logic              d_jal;

   qerv_pkg::alu_op_e       alu_op;
   qerv_pkg::rd_src_e       rd_src;
   logic                    rd_wen;
   logic                    op_b_imm;
   logic                    jal;
   logic [`QERV_XLEN-1:12]  ir_hi;
   qerv_pkg::word_t         imm_word;
   qerv_pkg::word_t         imm_sr;

   assign opcode = i_ibus_rdt[6:0];
   assign funct3 = i_ibus_rdt[14:12];

   always_comb begin
      d_alu_op   = qerv_pkg::ALU_ADD;
      d_src      = qerv_pkg::RD_ALU;
      d_wen      = 1'b0;
      d_op_b_imm = 1'b0;
      d_jal      = 1'b0;
      f3_ok      = 1'b1;
      case (funct3)
         3'b000: begin
            // Bit 30 selects SUB, register form only
            if (opcode == OPC_OP && i_ibus_rdt[30])
               d_alu_op = qerv_pkg::ALU_SUB;
         end
         3'b100:  d_alu_op = qerv_pkg::ALU_XOR;
         3'b110:  d_alu_op = qerv_pkg::ALU_OR;
         3'b111:  d_alu_op = qerv_pkg::ALU_AND;
         default: f3_ok = 1'b0;
      endcase
      case (opcode)
         OPC_OP: d_wen = f3_ok;
         OPC_OP_IMM: begin
            d_wen      = f3_ok;
            d_op_b_imm = 1'b1;
         end
         OPC_LUI: begin
            d_wen = 1'b1;
            d_src = qerv_pkg::RD_IMM;
         end
         OPC_JAL: begin
            d_wen = 1'b1;
            d_src = qerv_pkg::RD_LINK;
            d_jal = 1'b1;
         end
         // Anything else runs as a no-op
         default: d_wen = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         alu_op   <= qerv_pkg::ALU_ADD;
         rd_src   <= qerv_pkg::RD_ALU;
         rd_wen   <= 1'b0;
         op_b_imm <= 1'b0;
         jal      <= 1'b0;
      end else if (i_ibus_ack) begin
         alu_op   <= d_alu_op;
         rd_src   <= d_src;
         rd_wen   <= d_wen;
         op_b_imm <= d_op_b_imm;
         jal      <= d_jal;
      end
   end

   // J, U or I immediate from the latched upper bits
   always_comb begin
      if (jal)
         imm_word = {{12{ir_hi[31]}}, ir_hi[19:12], ir_hi[20], ir_hi[30:21], 1'b0};
      else if (rd_src == qerv_pkg::RD_IMM)
         imm_word = {ir_hi, 12'b0};
      else
         imm_word = {{20{ir_hi[31]}}, ir_hi[31:20]};
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         dec.rs1_addr <= i_ibus_rdt[19:15];
         dec.rs2_addr <= i_ibus_rdt[24:20];
         dec.rd_addr  <= i_ibus_rdt[11:7];
         ir_hi        <= i_ibus_rdt[`QERV_XLEN-1:12];
      end
      if (step.exec_start)
         imm_sr <= imm_word;
      else if (step.cnt_en)
         imm_sr <= {{`QERV_W{1'b0}}, imm_sr[`QERV_XLEN-1:`QERV_W]};
   end

   assign dec.alu_op   = alu_op;
   assign dec.rd_src   = rd_src;
   assign dec.rd_wen   = rd_wen;
   assign dec.op_b_imm = op_b_imm;
   assign dec.jal      = jal;
   assign dec.imm_nib  = imm_sr[`QERV_W-1:0];

endmodule
`default_nettype wire

//--- logic/qerv_ifs.sv
`timescale 1ns/1ps
`include "qerv_config.svh"

// Step timing from the sequencer
interface qerv_step_if;
   logic cnt_en;
   logic cnt0;
   logic cnt_done;
   logic exec_start;

   modport seq  (output cnt_en, cnt0, cnt_done, exec_start);
   modport user (input cnt_en, cnt0, cnt_done, exec_start);
endinterface

// Decoded instruction controls
interface qerv_dec_if;
   qerv_pkg::reg_addr_t rs1_addr;
   qerv_pkg::reg_addr_t rs2_addr;
   qerv_pkg::reg_addr_t rd_addr;
   logic                rd_wen;
   qerv_pkg::rd_src_e   rd_src;
   qerv_pkg::alu_op_e   alu_op;
   logic                op_b_imm;
   logic                jal;
   qerv_pkg::nibble_t   imm_nib;

   modport dec (
      output rs1_addr, rs2_addr, rd_addr, rd_wen, rd_src,
             alu_op, op_b_imm, jal, imm_nib
   );
   modport alu  (input alu_op, op_b_imm, imm_nib);
   modport ctrl (input jal, imm_nib);
   modport rf   (input rs1_addr, rs2_addr, rd_addr, rd_wen, rd_src, imm_nib);
endinterface

//--- logic/qerv_pkg.sv
`include "qerv_config.svh"

package qerv_pkg;

   typedef logic [`QERV_W-1:0] nibble_t;

   typedef logic [`QERV_XLEN-1:0] word_t;

   typedef logic [`QERV_RAW-1:0] reg_addr_t;

   typedef logic [$clog2(`QERV_STEPS)-1:0] step_t;

   // ALU function for the current instruction
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // Source of the rd write nibble
   typedef enum logic [1:0] {
      RD_ALU,
      RD_LINK,
      RD_IMM
   } rd_src_e;

   typedef enum logic [1:0] {
      S_FETCH,
      S_RF_REQ,
      S_EXEC
   } seq_state_e;

endpackage

//--- logic/qerv_rf_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_rf_if (
   input  qerv_pkg::nibble_t   i_rdata0,
   input  qerv_pkg::nibble_t   i_rdata1,
   output qerv_pkg::nibble_t   o_rs1,
   output qerv_pkg::nibble_t   o_rs2,
   input  qerv_pkg::nibble_t   i_alu_rd,
   input  qerv_pkg::nibble_t   i_link,
   qerv_step_if.user           step,
   qerv_dec_if.rf              dec,
   output qerv_pkg::reg_addr_t o_rreg0,
   output qerv_pkg::reg_addr_t o_rreg1,
   output qerv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output qerv_pkg::nibble_t   o_wdata0
);

   // Operand nibbles arrive least significant first
   assign o_rs1 = i_rdata0;
   assign o_rs2 = i_rdata1;

   assign o_rreg0 = dec.rs1_addr;
   assign o_rreg1 = dec.rs2_addr;
   assign o_wreg0 = dec.rd_addr;

   // x0 is never written
   assign o_wen0 = step.cnt_en && dec.rd_wen && (|dec.rd_addr);

   always_comb begin
      case (dec.rd_src)
         qerv_pkg::RD_LINK: o_wdata0 = i_link;
         qerv_pkg::RD_IMM:  o_wdata0 = dec.imm_nib;
         default:           o_wdata0 = i_alu_rd;
      endcase
   end

endmodule
`default_nettype wire

//--- logic/qerv_state.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_state (
   input  logic       clk,
   input  logic       i_arst_n,
   input  logic       i_ibus_ack,
   output logic       o_ibus_cyc,
   output logic       o_rf_rreq,
   input  logic       i_rf_ready,
   qerv_step_if.seq   step
);

   qerv_pkg::seq_state_e state;
   qerv_pkg::seq_state_e state_nxt;
   qerv_pkg::step_t      cnt;
   logic                 exec;
   logic                 last_step;
   logic                 start_q;

   assign exec      = (state == qerv_pkg::S_EXEC);
   assign last_step = exec && (cnt == qerv_pkg::step_t'(`QERV_STEPS - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         qerv_pkg::S_FETCH: begin
            if (i_ibus_ack)
               state_nxt = qerv_pkg::S_RF_REQ;
         end
         qerv_pkg::S_RF_REQ: begin
            if (i_rf_ready)
               state_nxt = qerv_pkg::S_EXEC;
         end
         qerv_pkg::S_EXEC: begin
            if (last_step)
               state_nxt = qerv_pkg::S_FETCH;
         end
         default: state_nxt = qerv_pkg::S_FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= qerv_pkg::S_FETCH;
         cnt     <= '0;
         start_q <= 1'b0;
      end else begin
         state   <= state_nxt;
         // First RF_REQ cycle, instruction register now valid
         start_q <= (state == qerv_pkg::S_FETCH) && i_ibus_ack;
         // Wraps back to zero after the last step
         if (exec)
            cnt <= cnt + qerv_pkg::step_t'(1);
      end
   end

   // Bus requests follow the state directly
   assign o_ibus_cyc = (state == qerv_pkg::S_FETCH);
   assign o_rf_rreq  = (state == qerv_pkg::S_RF_REQ);

   assign step.cnt_en     = exec;
   assign step.cnt0       = exec && (cnt == '0);
   assign step.cnt_done   = last_step;
   assign step.exec_start = start_q;

endmodule
`default_nettype wire

//--- logic/qerv_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "qerv_config.svh"

module qerv_top (
   input  logic                clk,
   input  logic                i_arst_n,
   output qerv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  qerv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output qerv_pkg::reg_addr_t o_rreg0,
   output qerv_pkg::reg_addr_t o_rreg1,
   input  qerv_pkg::nibble_t   i_rdata0,
   input  qerv_pkg::nibble_t   i_rdata1,
   output qerv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output qerv_pkg::nibble_t   o_wdata0
);

   qerv_pkg::nibble_t rs1;
   qerv_pkg::nibble_t rs2;
   qerv_pkg::nibble_t alu_rd;
   qerv_pkg::nibble_t link;

   qerv_step_if step_bus ();
   qerv_dec_if  dec_bus ();

   qerv_state u_state (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .step       (step_bus)
   );

   qerv_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .step       (step_bus),
      .dec        (dec_bus)
   );

   qerv_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .step     (step_bus),
      .dec      (dec_bus),
      .o_rd     (alu_rd)
   );

   qerv_ctrl u_ctrl (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .step       (step_bus),
      .dec        (dec_bus),
      .o_ibus_adr (o_ibus_adr),
      .o_link     (link)
   );

   qerv_rf_if u_rf_if (
      .i_rdata0 (i_rdata0),
      .i_rdata1 (i_rdata1),
      .o_rs1    (rs1),
      .o_rs2    (rs2),
      .i_alu_rd (alu_rd),
      .i_link   (link),
      .step     (step_bus),
      .dec      (dec_bus),
      .o_rreg0  (o_rreg0),
      .o_rreg1  (o_rreg1),
      .o_wreg0  (o_wreg0),
      .o_wen0   (o_wen0),
      .o_wdata0 (o_wdata0)
   );

endmodule
`default_nettype wire

//--- sim/qerv_tb.sv
`timescale 1ns/1ps
`include "qerv_config.svh"

module qerv_tb;

   localparam int N_ROWS  = 16;
   localparam int TIMEOUT = 50;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   logic        clk;
   logic        i_arst_n;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   logic        i_rf_ready;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic [3:0]  i_rdata0;
   logic [3:0]  i_rdata1;
   logic [4:0]  o_wreg0;
   logic        o_wen0;
   logic [3:0]  o_wdata0;

   logic [31:0] rf_rs1_val;
   logic [31:0] rf_rs2_val;
   logic [1:0]  rf_delay;
   logic [31:0] rf_wdata;
   int          rf_wen_cnt;
   int          rf_served;
   int          errors;
   int          checks;

   // One row per instruction
   string       name_tab [N_ROWS];
   logic [31:0] instr_tab [N_ROWS];
   logic [31:0] rs1_tab [N_ROWS];
   logic [31:0] rs2_tab [N_ROWS];
   logic [4:0]  rreg0_tab [N_ROWS];
   logic [4:0]  rreg1_tab [N_ROWS];
   logic        wen_tab [N_ROWS];
   logic [4:0]  wreg_tab [N_ROWS];
   logic [31:0] wdata_tab [N_ROWS];
   logic [31:0] npc_tab [N_ROWS];

   qerv_top DUT (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   qerv_tb_rf u_rf (
      .clk       (clk),
      .i_rreq    (o_rf_rreq),
      .o_ready   (i_rf_ready),
      .o_rdata0  (i_rdata0),
      .o_rdata1  (i_rdata1),
      .i_wen     (o_wen0),
      .i_wdata   (o_wdata0),
      .i_rs1_val (rf_rs1_val),
      .i_rs2_val (rf_rs2_val),
      .i_delay   (rf_delay),
      .o_wdata   (rf_wdata),
      .o_wen_cnt (rf_wen_cnt),
      .o_served  (rf_served)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // RISC-V instruction encoders
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
         input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic set_row(input int i, input string name, input logic [31:0] instr,
         input logic [31:0] rs1, input logic [31:0] rs2, input logic [4:0] r0,
         input logic [4:0] r1, input logic wen, input logic [4:0] wreg,
         input logic [31:0] wdata, input logic [31:0] npc);
      name_tab[i]  = name;
      instr_tab[i] = instr;
      rs1_tab[i]   = rs1;
      rs2_tab[i]   = rs2;
      rreg0_tab[i] = r0;
      rreg1_tab[i] = r1;
      wen_tab[i]   = wen;
      wreg_tab[i]  = wreg;
      wdata_tab[i] = wdata;
      npc_tab[i]   = npc;
   endtask

   task automatic fill_table();
      set_row(0, "ADD", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP),
              32'h1234_5678, 32'h0fed_cba9, 5'd1, 5'd2, 1'b1, 5'd3,
              32'h1234_5678 + 32'h0fed_cba9, 32'h04);
      set_row(1, "SUB wrap", r_type(7'h20, 5'd7, 5'd6, 3'b000, 5'd5, OPC_OP),
              32'd5, 32'd7, 5'd6, 5'd7, 1'b1, 5'd5, 32'd5 - 32'd7, 32'h08);
      set_row(2, "SUB borrow", r_type(7'h20, 5'd10, 5'd9, 3'b000, 5'd8, OPC_OP),
              32'h8000_0000, 32'd1, 5'd9, 5'd10, 1'b1, 5'd8, 32'h7fff_ffff, 32'h0c);
      set_row(3, "AND", r_type(7'h00, 5'd13, 5'd12, 3'b111, 5'd11, OPC_OP),
              32'hf0f0_1234, 32'h0ff0_ff00, 5'd12, 5'd13, 1'b1, 5'd11,
              32'hf0f0_1234 & 32'h0ff0_ff00, 32'h10);
      set_row(4, "OR", r_type(7'h00, 5'd16, 5'd15, 3'b110, 5'd14, OPC_OP),
              32'ha050_0003, 32'h050a_3000, 5'd15, 5'd16, 1'b1, 5'd14,
              32'ha050_0003 | 32'h050a_3000, 32'h14);
      set_row(5, "XOR", r_type(7'h00, 5'd19, 5'd18, 3'b100, 5'd17, OPC_OP),
              32'hdead_beef, 32'hffff_0000, 5'd18, 5'd19, 1'b1, 5'd17,
              32'hdead_beef ^ 32'hffff_0000, 32'h18);
      set_row(6, "ADD carry", r_type(7'h00, 5'd22, 5'd21, 3'b000, 5'd20, OPC_OP),
              32'hffff_ffff, 32'd1, 5'd21, 5'd22, 1'b1, 5'd20, 32'd0, 32'h1c);
      // Immediate rows serve a rs2 value that must not be used
      set_row(7, "ADDI", i_type(12'hffb, 5'd1, 3'b000, 5'd4),
              32'd10, 32'hdead_beef, 5'd1, 5'h1b, 1'b1, 5'd4, 32'd5, 32'h20);
      set_row(8, "ANDI", i_type(12'hf00, 5'd2, 3'b111, 5'd5),
              32'h1234_5678, 32'hdead_beef, 5'd2, 5'd0, 1'b1, 5'd5, 32'h1234_5600, 32'h24);
      set_row(9, "ORI", i_type(12'h800, 5'd3, 3'b110, 5'd6),
              32'h0000_0123, 32'hdead_beef, 5'd3, 5'd0, 1'b1, 5'd6, 32'hffff_f923, 32'h28);
      set_row(10, "XORI", i_type(12'hfff, 5'd4, 3'b100, 5'd7),
              32'h0f0f_0f0f, 32'hdead_beef, 5'd4, 5'h1f, 1'b1, 5'd7, 32'hf0f0_f0f0, 32'h2c);
      set_row(11, "LUI", lui_word(20'habcde, 5'd8),
              32'h1111_1111, 32'h2222_2222, 5'h1b, 5'h1c, 1'b1, 5'd8, 32'habcd_e000, 32'h30);
      set_row(12, "JAL fwd", jal_word(21'h000100, 5'd1),
              32'h3333_3333, 32'h4444_4444, 5'd0, 5'd0, 1'b1, 5'd1, 32'h34, 32'h130);
      set_row(13, "JAL back", jal_word(21'h1fffd8, 5'd2),
              32'h5555_5555, 32'h6666_6666, 5'h1f, 5'h19, 1'b1, 5'd2, 32'h134, 32'h108);
      set_row(14, "ADD x0", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OPC_OP),
              32'd7, 32'd9, 5'd1, 5'd2, 1'b0, 5'd0, 32'd0, 32'h10c);
      set_row(15, "BEQ no-op", r_type(7'h00, 5'd4, 5'd3, 3'b000, 5'd9, OPC_BRANCH),
              32'd1, 32'd1, 5'd3, 5'd4, 1'b0, 5'd9, 32'd0, 32'h110);
   endtask

   task automatic check_val(input string name, input string what, input logic [31:0] exp,
         input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("CHECK FAILED %s (%s): expected %h, actual %h", name, what, exp, act);
      end
   endtask

   task automatic await_cyc(input string name, input logic [31:0] pc, output logic ok);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (o_ibus_cyc !== 1'b1 && n < TIMEOUT);
      ok = (o_ibus_cyc === 1'b1);
      if (!ok) begin
         errors++;
         $display("Timeout: %s saw no instruction fetch within %0d cycles", name, TIMEOUT);
      end else
         check_val(name, "fetch address", pc, o_ibus_adr);
   endtask

   task automatic fetch_instr(input int row, input logic [31:0] pc, input logic [1:0] delay,
         output logic ok);
      await_cyc(name_tab[row], pc, ok);
      if (ok) begin
         repeat (delay) @(posedge clk);
         i_ibus_rdt <= instr_tab[row];
         i_ibus_ack <= 1'b1;
         @(posedge clk);
         check_val(name_tab[row], "ibus_cyc at ack", 32'd1, o_ibus_cyc);
         check_val(name_tab[row], "ibus_adr at ack", pc, o_ibus_adr);
         i_ibus_ack <= 1'b0;
      end
   endtask

   task automatic watch_rreq(input int row, output logic ok);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (o_rf_rreq !== 1'b1 && n < TIMEOUT);
      ok = (o_rf_rreq === 1'b1);
      if (!ok) begin
         errors++;
         $display("Timeout: %s raised no register-file request", name_tab[row]);
      end else begin
         check_val(name_tab[row], "rreg0", rreg0_tab[row], o_rreg0);
         check_val(name_tab[row], "rreg1", rreg1_tab[row], o_rreg1);
         check_val(name_tab[row], "wreg0", wreg_tab[row], o_wreg0);
         check_val(name_tab[row], "ibus_cyc after ack", 32'd0, o_ibus_cyc);
         check_val(name_tab[row], "wen0 before steps", 32'd0, o_wen0);
      end
   endtask

   task automatic collect_result(input int row, input int served_prev, output logic ok);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (rf_served == served_prev && n < TIMEOUT);
      ok = (rf_served != served_prev);
      if (!ok) begin
         errors++;
         $display("Timeout: %s never finished its execute steps", name_tab[row]);
      end else if (wen_tab[row]) begin
         check_val(name_tab[row], "write nibbles", `QERV_STEPS, rf_wen_cnt);
         check_val(name_tab[row], "write data", wdata_tab[row], rf_wdata);
      end else
         check_val(name_tab[row], "write nibbles", 32'd0, rf_wen_cnt);
   endtask

   initial begin
      int unsigned seed;
      int          row;
      int          served_prev;
      logic [31:0] exp_pc;
      logic [1:0]  ack_delay;
      logic        ok;

      seed = 32'hbedd_fb06;
      void'($urandom(seed));
      errors     = 0;
      checks     = 0;
      i_arst_n   = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      rf_rs1_val = '0;
      rf_rs2_val = '0;
      rf_delay   = '0;
      fill_table();

      repeat (5) @(posedge clk);
      check_val("reset", "ibus_cyc", 32'd1, o_ibus_cyc);
      check_val("reset", "rf_rreq", 32'd0, o_rf_rreq);
      check_val("reset", "wen0", 32'd0, o_wen0);
      i_arst_n <= 1'b1;

      exp_pc = `QERV_RESET_PC;
      ok     = 1'b1;
      for (row = 0; row < N_ROWS && ok; row++) begin
         rf_rs1_val  = rs1_tab[row];
         rf_rs2_val  = rs2_tab[row];
         rf_delay    = 2'($urandom_range(3, 0));
         ack_delay   = 2'($urandom_range(3, 0));
         served_prev = rf_served;
         fetch_instr(row, exp_pc, ack_delay, ok);
         if (ok)
            watch_rreq(row, ok);
         if (ok)
            collect_result(row, served_prev, ok);
         exp_pc = npc_tab[row];
      end
      // Next PC of the last row
      if (ok)
         await_cyc("final fetch", exp_pc, ok);

      $display("Run finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- sim/qerv_tb_rf.sv
`timescale 1ns/1ps
`include "qerv_config.svh"

module qerv_tb_rf (
   input  logic                  clk,
   input  logic                  i_rreq,
   output logic                  o_ready,
   output logic [`QERV_W-1:0]    o_rdata0,
   output logic [`QERV_W-1:0]    o_rdata1,
   input  logic                  i_wen,
   input  logic [`QERV_W-1:0]    i_wdata,
   input  logic [`QERV_XLEN-1:0] i_rs1_val,
   input  logic [`QERV_XLEN-1:0] i_rs2_val,
   input  logic [1:0]            i_delay,
   output logic [`QERV_XLEN-1:0] o_wdata,
   output int                    o_wen_cnt,
   output int                    o_served
);

   initial begin
      logic [`QERV_XLEN-1:0] acc;
      int                    cnt;
      int                    k;

      o_ready   = 1'b0;
      o_rdata0  = '0;
      o_rdata1  = '0;
      o_wdata   = '0;
      o_wen_cnt = 0;
      o_served  = 0;
      forever begin
         @(posedge clk);
         if (i_rreq === 1'b1) begin
            repeat (i_delay) @(posedge clk);
            o_ready <= 1'b1;
            // Ready is sampled here, step 0 follows
            @(posedge clk);
            o_ready <= 1'b0;
            acc = '0;
            cnt = 0;
            for (k = 0; k < `QERV_STEPS; k++) begin
               o_rdata0 <= i_rs1_val[k*`QERV_W +: `QERV_W];
               o_rdata1 <= i_rs2_val[k*`QERV_W +: `QERV_W];
               @(posedge clk);
               if (i_wen === 1'b1) begin
                  acc[k*`QERV_W +: `QERV_W] = i_wdata;
                  cnt++;
               end
            end
            o_wdata   <= acc;
            o_wen_cnt <= cnt;
            o_served  <= o_served + 1;
         end
      end
   end

endmodule

//--- src.f
+incdir+logic
logic/qerv_pkg.sv
logic/qerv_ifs.sv
logic/qerv_state.sv
logic/qerv_decode.sv
logic/qerv_alu.sv
logic/qerv_ctrl.sv
logic/qerv_rf_if.sv
logic/qerv_top.sv
sim/qerv_tb_rf.sv
sim/qerv_tb.sv
